/* filelist.f */
+incdir+include
src/soc_periph_pkg.sv
src/periph_bus_ctrl.sv
src/periph_gpio.sv
src/periph_timer.sv
src/periph_irq_ctrl.sv
src/soc_periph_top.sv
verification/soc_periph_props.sv
verification/soc_periph_tb.sv

/* include/soc_periph_macros.svh */
// constants for the peripheral subsystem; the register offsets assume 32-bit aligned access
`ifndef SOC_PERIPH_MACROS_SVH
`define SOC_PERIPH_MACROS_SVH

////////////////////////////////////////
// identification
`define SOC_HW_ID              32'h5350_4331
`define SOC_DEV_COUNT          32'd4
`define SOC_GPIO_WIDTH         12

////////////////////////////////////////
// regions, taken from address bits 11..8
`define SOC_REGION_INFO        4'd0
`define SOC_REGION_GPIO        4'd1
`define SOC_REGION_TIMER       4'd2
`define SOC_REGION_IRQ         4'd3

////////////////////////////////////////
// register offsets inside a region
`define SOC_INFO_REG_HW_ID     6'h00
`define SOC_INFO_REG_DEV_COUNT 6'h04
`define SOC_GPIO_REG_INPUT     6'h00
`define SOC_GPIO_REG_OUTPUT    6'h04
`define SOC_GPIO_REG_DIR       6'h08
`define SOC_GPIO_REG_IE        6'h0C
`define SOC_GPIO_REG_PEND      6'h10
`define SOC_TIMER_REG_CNT_LO   6'h00
`define SOC_TIMER_REG_CNT_HI   6'h04
`define SOC_TIMER_REG_CMP_LO   6'h08
`define SOC_TIMER_REG_CMP_HI   6'h0C
`define SOC_IRQ_REG_PEND       6'h00
`define SOC_IRQ_REG_ENABLE     6'h04
`define SOC_IRQ_REG_SOFT       6'h08
`define SOC_IRQ_REG_CLAIM      6'h0C

`endif

/* src/periph_bus_ctrl.sv */
// single-cycle decoder; regions 4..15 answer with err set and zero data, bits 7..6 of addr ignored
`include "soc_periph_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module periph_bus_ctrl
  import soc_periph_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_arst_n,
  input  periph_req_t  i_req,
  output periph_rsp_t  o_rsp,
  output periph_lreq_t o_gpio_req,
  output periph_lreq_t o_timer_req,
  output periph_lreq_t o_irq_req,
  input  logic [31:0]  i_gpio_rdata,
  input  logic [31:0]  i_timer_rdata,
  input  logic [31:0]  i_irq_rdata
);

  logic [3:0]  region;
  logic [5:0]  offset;
  logic [31:0] rdata_sel;
  logic        err_sel;
  logic        rsp_valid_q;
  logic        rsp_err_q;
  logic [31:0] rsp_rdata_q;

  // strobes for one device gated by its region match
  function automatic periph_lreq_t make_lreq(input periph_req_t req, input logic sel);
    periph_lreq_t lreq;
    lreq.we     = req.valid & req.we & sel;
    lreq.re     = req.valid & ~req.we & sel;
    lreq.offset = req.addr[5:0];
    lreq.wdata  = req.wdata;
    return lreq;
  endfunction

  assign region = i_req.addr[11:8];
  assign offset = i_req.addr[5:0];

  assign o_gpio_req  = make_lreq(i_req, region == `SOC_REGION_GPIO);
  assign o_timer_req = make_lreq(i_req, region == `SOC_REGION_TIMER);
  assign o_irq_req   = make_lreq(i_req, region == `SOC_REGION_IRQ);

  ////////////////////////////////////////
  // read data select
  always_comb
  begin
    rdata_sel = '0;
    err_sel   = 1'b0;
    case (region)
      `SOC_REGION_INFO:
      begin
        // info region is read-only so writes are dropped
        if (offset == `SOC_INFO_REG_HW_ID)
          rdata_sel = `SOC_HW_ID;
        else if (offset == `SOC_INFO_REG_DEV_COUNT)
          rdata_sel = `SOC_DEV_COUNT;
      end
      `SOC_REGION_GPIO:  rdata_sel = i_gpio_rdata;
      `SOC_REGION_TIMER: rdata_sel = i_timer_rdata;
      `SOC_REGION_IRQ:   rdata_sel = i_irq_rdata;
      // unmapped region keeps data at zero
      default:           err_sel = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // response register
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      rsp_valid_q <= 1'b0;
    else
      rsp_valid_q <= i_req.valid;
  end

  // payload only loads on an access
  always_ff @(posedge i_clk)
  begin
    if (i_req.valid)
    begin
      rsp_err_q   <= err_sel;
      rsp_rdata_q <= rdata_sel;
    end
  end

  assign o_rsp = '{valid: rsp_valid_q, err: rsp_err_q, rdata: rsp_rdata_q};

endmodule

`default_nettype wire

/* src/periph_gpio.sv */
// gpio with a 2-flop input synchronizer; pins narrower than 32 read back zero-extended
`include "soc_periph_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module periph_gpio
  import soc_periph_pkg::*;
(
  input  logic                       i_clk,
  input  logic                       i_arst_n,
  input  periph_lreq_t               i_req,
  output logic [31:0]                o_rdata,
  input  logic [`SOC_GPIO_WIDTH-1:0] i_gpio,
  output logic [`SOC_GPIO_WIDTH-1:0] o_gpio,
  output logic [`SOC_GPIO_WIDTH-1:0] o_gpio_dir,
  output logic                       o_irq
);

  localparam int W   = `SOC_GPIO_WIDTH;
  localparam int PAD = 32 - W;

  logic [W-1:0] meta_q;
  logic [W-1:0] sync_q;
  logic [W-1:0] prev_q;
  logic [W-1:0] ie_q;
  logic [W-1:0] pend_q;
  logic [W-1:0] rise;
  logic [W-1:0] clr;
  logic [W-1:0] rd_sel;

  // rising edge seen after the synchronizer
  assign rise = sync_q & ~prev_q;
  // write one to clear
  assign clr  = (i_req.we && i_req.offset == `SOC_GPIO_REG_PEND) ? i_req.wdata[W-1:0] : '0;

  ////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      meta_q     <= '0;
      sync_q     <= '0;
      prev_q     <= '0;
      o_gpio     <= '0;
      o_gpio_dir <= '0;
      ie_q       <= '0;
      pend_q     <= '0;
    end
    else
    begin
      meta_q <= i_gpio;
      sync_q <= meta_q;
      prev_q <= sync_q;
      // a new edge wins over a clear in the same cycle
      pend_q <= (pend_q & ~clr) | (rise & ie_q);
      if (i_req.we)
      begin
        case (i_req.offset)
          `SOC_GPIO_REG_OUTPUT: o_gpio     <= i_req.wdata[W-1:0];
          `SOC_GPIO_REG_DIR:    o_gpio_dir <= i_req.wdata[W-1:0];
          `SOC_GPIO_REG_IE:     ie_q       <= i_req.wdata[W-1:0];
          default:              ;
        endcase
      end
    end
  end

  // read mux for the current offset
  always_comb
  begin
    case (i_req.offset)
      `SOC_GPIO_REG_INPUT:  rd_sel = sync_q;
      `SOC_GPIO_REG_OUTPUT: rd_sel = o_gpio;
      `SOC_GPIO_REG_DIR:    rd_sel = o_gpio_dir;
      `SOC_GPIO_REG_IE:     rd_sel = ie_q;
      `SOC_GPIO_REG_PEND:   rd_sel = pend_q;
      default:              rd_sel = '0;
    endcase
  end

  assign o_rdata = {{PAD{1'b0}}, rd_sel};
  assign o_irq   = |pend_q;

endmodule

`default_nettype wire

/* src/periph_irq_ctrl.sv */
// three sources on one line; a claim read has no side effect, sources are cleared at their device
`include "soc_periph_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module periph_irq_ctrl
  import soc_periph_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_arst_n,
  input  periph_lreq_t i_req,
  output logic [31:0]  o_rdata,
  input  logic         i_gpio_irq,
  input  logic         i_mtip,
  output logic         o_irq
);

  logic [3:1] src;
  logic [3:1] pend_q;
  logic [3:1] en_q;
  logic       soft_q;
  logic [3:1] act;
  irq_src_e   claim;

  // source levels indexed by irq_src_e
  assign src = {soft_q, i_mtip, i_gpio_irq};
  assign act = pend_q & en_q;

  ////////////////////////////////////////
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      pend_q <= '0;
      en_q   <= '0;
      soft_q <= 1'b0;
      o_irq  <= 1'b0;
    end
    else
    begin
      pend_q <= src;
      // same sample as pend_q, so o_irq lags a source by one cycle
      o_irq  <= |(src & en_q);
      if (i_req.we && i_req.offset == `SOC_IRQ_REG_ENABLE)
        en_q <= i_req.wdata[3:1];
      if (i_req.we && i_req.offset == `SOC_IRQ_REG_SOFT)
        soft_q <= i_req.wdata[0];
    end
  end

  ////////////////////////////////////////
  // claim, lowest active source first
  always_comb
  begin
    if (act[IRQ_SRC_GPIO])
      claim = IRQ_SRC_GPIO;
    else if (act[IRQ_SRC_TIMER])
      claim = IRQ_SRC_TIMER;
    else if (act[IRQ_SRC_SOFT])
      claim = IRQ_SRC_SOFT;
    else
      claim = IRQ_SRC_NONE;
  end

  always_comb
  begin
    case (i_req.offset)
      // bit 0 unused, source numbers start at 1
      `SOC_IRQ_REG_PEND:   o_rdata = {28'd0, pend_q, 1'b0};
      `SOC_IRQ_REG_ENABLE: o_rdata = {28'd0, en_q, 1'b0};
      `SOC_IRQ_REG_SOFT:   o_rdata = {31'd0, soft_q};
      `SOC_IRQ_REG_CLAIM:  o_rdata = {30'd0, claim};
      default:             o_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* src/periph_timer.sv */
// 64-bit timer, the halves are read separately so a carry between two reads is not hidden
`include "soc_periph_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module periph_timer
  import soc_periph_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_arst_n,
  input  periph_lreq_t i_req,
  output logic [31:0]  o_rdata,
  output logic         o_mtip
);

  logic [63:0] cnt_q;
  logic [63:0] cmp_q;

  ////////////////////////////////////////
  // free-running counter
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_q + 64'd1;
  end

  // compare starts at all ones so no interrupt fires out of reset
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      cmp_q <= '1;
    else if (i_req.we)
    begin
      if (i_req.offset == `SOC_TIMER_REG_CMP_LO)
        cmp_q[31:0] <= i_req.wdata;
      else if (i_req.offset == `SOC_TIMER_REG_CMP_HI)
        cmp_q[63:32] <= i_req.wdata;
    end
  end

  ////////////////////////////////////////
  always_comb
  begin
    case (i_req.offset)
      `SOC_TIMER_REG_CNT_LO: o_rdata = cnt_q[31:0];
      `SOC_TIMER_REG_CNT_HI: o_rdata = cnt_q[63:32];
      `SOC_TIMER_REG_CMP_LO: o_rdata = cmp_q[31:0];
      `SOC_TIMER_REG_CMP_HI: o_rdata = cmp_q[63:32];
      default:               o_rdata = '0;
    endcase
  end

  // level, stays high until compare is moved past the counter
  assign o_mtip = (cnt_q >= cmp_q);

endmodule

`default_nettype wire

/* src/soc_periph_pkg.sv */
// bus types of the subsystem; the host bus has no back-pressure and a fixed one-cycle response
`default_nettype none

package soc_periph_pkg;

  ////////////////////////////////////////
  // host side

  // one-cycle request strobe, a new access may start every cycle
  typedef struct packed {
    logic        valid;
    logic        we;
    // bits 11..8 select the region, bits 5..0 the register
    logic [11:0] addr;
    logic [31:0] wdata;
  } periph_req_t;

  // response pulse, one clock after the request
  typedef struct packed {
    logic        valid;
    // unmapped region
    logic        err;
    logic [31:0] rdata;
  } periph_rsp_t;

  ////////////////////////////////////////
  // device side

  // only the addressed device sees we or re high
  typedef struct packed {
    logic        we;
    logic        re;
    logic [5:0]  offset;
    logic [31:0] wdata;
  } periph_lreq_t;

  // interrupt source numbers, also the claim values
  // lower number wins the claim
  typedef enum logic [1:0] {
    IRQ_SRC_NONE  = 2'd0,
    IRQ_SRC_GPIO  = 2'd1,
    IRQ_SRC_TIMER = 2'd2,
    IRQ_SRC_SOFT  = 2'd3
  } irq_src_e;

endpackage

`default_nettype wire

/* src/soc_periph_top.sv */
// peripheral subsystem top; one host bus master, no reset generator, i_arst_n comes in ready to use
`include "soc_periph_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module soc_periph_top
  import soc_periph_pkg::*;
(
  input  logic                       i_clk,
  input  logic                       i_arst_n,
  input  periph_req_t                i_req,
  output periph_rsp_t                o_rsp,
  input  logic [`SOC_GPIO_WIDTH-1:0] i_gpio,
  output logic [`SOC_GPIO_WIDTH-1:0] o_gpio,
  output logic [`SOC_GPIO_WIDTH-1:0] o_gpio_dir,
  output logic                       o_irq
);

  periph_lreq_t gpio_req;
  periph_lreq_t timer_req;
  periph_lreq_t irq_req;
  logic [31:0]  gpio_rdata;
  logic [31:0]  timer_rdata;
  logic [31:0]  irq_rdata;
  logic         gpio_irq;
  logic         mtip;

  ////////////////////////////////////////
  // bus controller, also answers the info region
  periph_bus_ctrl ctrl0 (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_req         (i_req),
    .o_rsp         (o_rsp),
    .o_gpio_req    (gpio_req),
    .o_timer_req   (timer_req),
    .o_irq_req     (irq_req),
    .i_gpio_rdata  (gpio_rdata),
    .i_timer_rdata (timer_rdata),
    .i_irq_rdata   (irq_rdata)
  );

  // region 1
  periph_gpio gpio0 (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_req      (gpio_req),
    .o_rdata    (gpio_rdata),
    .i_gpio     (i_gpio),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir),
    .o_irq      (gpio_irq)
  );

  // region 2
  periph_timer timer0 (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_req    (timer_req),
    .o_rdata  (timer_rdata),
    .o_mtip   (mtip)
  );

  ////////////////////////////////////////
  // region 3, gathers gpio, timer and software sources
  periph_irq_ctrl irqc0 (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_req      (irq_req),
    .o_rdata    (irq_rdata),
    .i_gpio_irq (gpio_irq),
    .i_mtip     (mtip),
    .o_irq      (o_irq)
  );

endmodule

`default_nettype wire

/* verification/soc_periph_props.sv */
// response timing checks on the bus controller; they hold only when the host bus is the sole master
`timescale 1ns/100ps
`default_nettype none

module soc_periph_props
  import soc_periph_pkg::*;
(
  input logic        i_clk,
  input logic        i_arst_n,
  input periph_req_t i_req,
  input periph_rsp_t o_rsp
);

  ////////////////////////////////////////
  // one response per request, one clock later
  a_rsp_follows_req: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
      i_req.valid |=> o_rsp.valid)
    else $error("no response one cycle after a request");

  // no response without a request
  a_no_extra_rsp: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
      !i_req.valid |=> !o_rsp.valid)
    else $error("response without a request one cycle earlier");

  // unmapped accesses carry zero data
  a_err_data_zero: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
      (o_rsp.valid && o_rsp.err) |-> (o_rsp.rdata == '0))
    else $error("error response with nonzero read data");

  a_valid_known: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
      !$isunknown(o_rsp.valid))
    else $error("response valid is unknown after reset");

endmodule

bind periph_bus_ctrl soc_periph_props props0 (
  .i_clk    (i_clk),
  .i_arst_n (i_arst_n),
  .i_req    (i_req),
  .o_rsp    (o_rsp)
);

`default_nettype wire

/* verification/soc_periph_tb.sv */
// random register test of the subsystem; the run is short, so the timer high word stays zero
`include "soc_periph_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module soc_periph_tb
  import soc_periph_pkg::*;
();

  localparam int W          = `SOC_GPIO_WIDTH;
  localparam int N_UNMAPPED = 20;
  localparam int N_INPUT    = 8;
  localparam int N_GPIO_WR  = 20;
  localparam int N_EDGE     = 12;
  localparam int N_TIMER    = 8;
  localparam int N_POLL     = 24;
  localparam int N_IRQ      = 12;
  // clock edges per bus access with slack
  localparam int ACC        = 3;
  localparam int CYCLE_LIMIT = 16 + (8 + N_UNMAPPED) * ACC + N_INPUT * (4 + ACC)
    + N_GPIO_WR * 2 * ACC + N_EDGE * (7 + 4 * ACC) + N_TIMER * (16 + 3 * ACC)
    + (6 + N_POLL) * ACC + N_IRQ * (2 + 5 * ACC) + 200;

  logic         i_clk;
  logic         i_arst_n;
  periph_req_t  i_req;
  periph_rsp_t  o_rsp;
  logic [W-1:0] i_gpio;
  logic [W-1:0] o_gpio;
  logic [W-1:0] o_gpio_dir;
  logic         o_irq;

  // model state
  logic [63:0]  model_cnt;
  logic [63:0]  last_cnt;
  logic [W-1:0] m_out;
  logic [W-1:0] m_dir;
  logic [W-1:0] m_ie;
  logic [W-1:0] m_pend;
  logic [W-1:0] m_in;
  logic [3:1]   m_en;
  logic         m_soft;
  logic         m_mtip;

  integer       seed;
  int           errors;
  int           checks;
  int           err0;
  int           chk0;
  int           cycle = 0;
  int           i;
  int           k;
  logic [31:0]  r;
  logic [31:0]  wd;
  logic [31:0]  rd;
  logic [31:0]  rd2;
  logic [5:0]   off;
  logic [3:0]   region;
  logic [63:0]  target;
  logic [W-1:0] nv;
  logic [W-1:0] rise;
  logic [3:1]   src;
  logic         seen_lo;
  logic         seen_hi;
  periph_rsp_t  rsp;

  soc_periph_top dut0 (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_req      (i_req),
    .o_rsp      (o_rsp),
    .i_gpio     (i_gpio),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir),
    .o_irq      (o_irq)
  );

  initial
  begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // time base is zero in reset and steps once per clock
  always @(posedge i_clk)
  begin
    if (!i_arst_n)
      model_cnt <= '0;
    else
      model_cnt <= model_cnt + 64'd1;
  end

  always @(posedge i_clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT)
    begin
      $display("run stopped, tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers
  function automatic logic [11:0] reg_addr(input logic [3:0] rgn, input logic [5:0] ofs);
    return {rgn, 2'b00, ofs};
  endfunction

  // lowest numbered active source wins
  function automatic logic [1:0] expected_claim(input logic [3:1] act);
    if (act[1])
      return 2'd1;
    else if (act[2])
      return 2'd2;
    else if (act[3])
      return 2'd3;
    return 2'd0;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // one access that returns after the response pulse
  task automatic bus_access(input logic we, input logic [11:0] addr,
                            input logic [31:0] wdata, output periph_rsp_t rsp_out);
    int waited;
    waited = 0;
    @(posedge i_clk);
    i_req <= '{valid: 1'b1, we: we, addr: addr, wdata: wdata};
    @(posedge i_clk);
    // counter value the timer holds at the sampling edge
    last_cnt = model_cnt;
    i_req <= '0;
    @(negedge i_clk);
    while (!o_rsp.valid && waited < 3)
    begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_rsp.valid)
    begin
      $display("no response to the access at address 0x%h", addr);
      errors++;
    end
    rsp_out = o_rsp;
  endtask

  task automatic read_reg(input logic [3:0] rgn, input logic [5:0] ofs, output logic [31:0] data);
    periph_rsp_t rd_rsp;
    bus_access(1'b0, reg_addr(rgn, ofs), 32'd0, rd_rsp);
    check_value("rsp.err on read", rd_rsp.err, 1'b0);
    data = rd_rsp.rdata;
  endtask

  task automatic write_reg(input logic [3:0] rgn, input logic [5:0] ofs, input logic [31:0] data);
    periph_rsp_t wr_rsp;
    bus_access(1'b1, reg_addr(rgn, ofs), data, wr_rsp);
    check_value("rsp.err on write", wr_rsp.err, 1'b0);
  endtask

  // every writable register against its shadow copy
  task automatic check_shadow();
    logic [31:0] val;
    read_reg(`SOC_REGION_GPIO, `SOC_GPIO_REG_OUTPUT, val);
    check_value("gpio output", val, m_out);
    read_reg(`SOC_REGION_GPIO, `SOC_GPIO_REG_DIR, val);
    check_value("gpio dir", val, m_dir);
    read_reg(`SOC_REGION_GPIO, `SOC_GPIO_REG_IE, val);
    check_value("gpio ie", val, m_ie);
    read_reg(`SOC_REGION_GPIO, `SOC_GPIO_REG_PEND, val);
    check_value("gpio pend", val, m_pend);
    read_reg(`SOC_REGION_IRQ, `SOC_IRQ_REG_ENABLE, val);
    check_value("irq enable", val, {m_en, 1'b0});
    read_reg(`SOC_REGION_IRQ, `SOC_IRQ_REG_SOFT, val);
    check_value("irq soft", val, m_soft);
  endtask

  task automatic finish_test(input string name);
    $display("test %-20s %0d checks, %0d errors", name, checks - chk0, errors - err0);
    chk0 = checks;
    err0 = errors;
  endtask

  ////////////////////////////////////////
  // test sequence
  initial
  begin
    seed     = 32'h9f0f38b7;
    errors   = 0;
    checks   = 0;
    err0     = 0;
    chk0     = 0;
    i_arst_n = 1'b0;
    i_req    = '0;
    i_gpio   = '0;
    m_out    = '0;
    m_dir    = '0;
    m_ie     = '0;
    m_pend   = '0;
    m_in     = '0;
    m_en     = '0;
    m_soft   = 1'b0;
    m_mtip   = 1'b0;
    repeat (16) @(posedge i_clk);
    i_arst_n <= 1'b1;

    // info region and unmapped regions
    read_reg(`SOC_REGION_INFO, `SOC_INFO_REG_HW_ID, rd);
    check_value("info hw id", rd, `SOC_HW_ID);
    read_reg(`SOC_REGION_INFO, `SOC_INFO_REG_DEV_COUNT, rd);
    check_value("info dev count", rd, `SOC_DEV_COUNT);
    for (i = 0; i < N_UNMAPPED; i++)
    begin
      r      = $random(seed);
      region = 4'(4 + r[7:0] % 12);
      bus_access(r[8], {region, r[21:14]}, $random(seed), rsp);
      check_value("rsp.err unmapped", rsp.err, 1'b1);
      check_value("rsp.rdata unmapped", rsp.rdata, 32'd0);
    end
    check_shadow();
    finish_test("info and unmapped");

    // input path first while all interrupt enables are still zero
    for (i = 0; i < N_INPUT; i++)
    begin
      @(posedge i_clk);
      nv = $random(seed);
      i_gpio <= nv;
      m_in = nv;
      repeat (3) @(posedge i_clk);
      read_reg(`SOC_REGION_GPIO, `SOC_GPIO_REG_INPUT, rd);
      check_value("gpio input", rd, m_in);
    end
    for (i = 0; i < N_GPIO_WR; i++)
    begin
      r  = $random(seed);
      wd = $random(seed);
      case (r % 3)
        0:       off = `SOC_GPIO_REG_OUTPUT;
        1:       off = `SOC_GPIO_REG_DIR;
        default: off = `SOC_GPIO_REG_IE;
      endcase
      write_reg(`SOC_REGION_GPIO, off, wd);
      if (off == `SOC_GPIO_REG_OUTPUT)
        m_out = wd[W-1:0];
      else if (off == `SOC_GPIO_REG_DIR)
        m_dir = wd[W-1:0];
      else
        m_ie = wd[W-1:0];
      read_reg(`SOC_REGION_GPIO, off, rd);
      // only the pin bits come back
      check_value("gpio readback", rd, wd[W-1:0]);
      check_value("o_gpio", o_gpio, m_out);
      check_value("o_gpio_dir", o_gpio_dir, m_dir);
    end
    finish_test("gpio registers");

    // rising edges on random pins
    wd = $random(seed);
    write_reg(`SOC_REGION_GPIO, `SOC_GPIO_REG_IE, wd);
    m_ie = wd[W-1:0];
    for (i = 0; i < N_EDGE; i++)
    begin
      @(posedge i_clk);
      nv = $random(seed);
      rise = nv & ~m_in;
      i_gpio <= nv;
      m_in = nv;
      repeat (6) @(posedge i_clk);
      m_pend = m_pend | (rise & m_ie);
      read_reg(`SOC_REGION_GPIO, `SOC_GPIO_REG_PEND, rd);
      check_value("gpio pend", rd, m_pend);
      read_reg(`SOC_REGION_IRQ, `SOC_IRQ_REG_PEND, rd);
      check_value("irq pend gpio bit", rd[1], |m_pend);
      if (i % 3 == 2)
      begin
        wd = $random(seed);
        write_reg(`SOC_REGION_GPIO, `SOC_GPIO_REG_PEND, wd);
        m_pend = m_pend & ~wd[W-1:0];
        read_reg(`SOC_REGION_GPIO, `SOC_GPIO_REG_PEND, rd);
        check_value("gpio pend after clear", rd, m_pend);
      end
    end
    finish_test("gpio edge interrupts");

    // the access task leaves one idle cycle and k extra edges give k+1 idle cycles
    for (i = 0; i < N_TIMER; i++)
    begin
      r = $random(seed);
      k = r[3:0];
      read_reg(`SOC_REGION_TIMER, `SOC_TIMER_REG_CNT_LO, rd);
      check_value("timer counter low", rd, last_cnt[31:0]);
      repeat (k) @(posedge i_clk);
      read_reg(`SOC_REGION_TIMER, `SOC_TIMER_REG_CNT_LO, rd2);
      check_value("timer counter low delta", rd2 - rd, k + 2);
      read_reg(`SOC_REGION_TIMER, `SOC_TIMER_REG_CNT_HI, rd);
      check_value("timer counter high", rd, last_cnt[63:32]);
    end
    finish_test("timer counting");

    // compare 20 counts ahead with the high word first to keep it out of reach
    read_reg(`SOC_REGION_TIMER, `SOC_TIMER_REG_CNT_LO, rd);
    target = last_cnt + 64'd20;
    write_reg(`SOC_REGION_TIMER, `SOC_TIMER_REG_CMP_HI, target[63:32]);
    write_reg(`SOC_REGION_TIMER, `SOC_TIMER_REG_CMP_LO, target[31:0]);
    seen_lo = 1'b0;
    seen_hi = 1'b0;
    for (i = 0; i < N_POLL; i++)
    begin
      read_reg(`SOC_REGION_IRQ, `SOC_IRQ_REG_PEND, rd);
      // irq pending shows the timer level one cycle late
      check_value("irq pend timer bit", rd[2], (last_cnt - 64'd1) >= target);
      if (rd[2])
        seen_hi = 1'b1;
      else
        seen_lo = 1'b1;
    end
    if (!(seen_lo && seen_hi))
    begin
      $display("timer pending did not go from low to high around the compare value");
      errors++;
    end
    // the timer level stays high until the compare is moved
    m_mtip = (last_cnt >= target);
    finish_test("timer compare");

    // enables and software bit against the source levels
    for (i = 0; i < N_IRQ; i++)
    begin
      if (i == N_IRQ / 2)
      begin
        // second half runs with the compare parked at all ones and no gpio pending
        write_reg(`SOC_REGION_TIMER, `SOC_TIMER_REG_CMP_HI, 32'hffff_ffff);
        write_reg(`SOC_REGION_TIMER, `SOC_TIMER_REG_CMP_LO, 32'hffff_ffff);
        m_mtip = 1'b0;
        write_reg(`SOC_REGION_GPIO, `SOC_GPIO_REG_PEND, '1);
        m_pend = '0;
      end
      wd = $random(seed);
      write_reg(`SOC_REGION_IRQ, `SOC_IRQ_REG_ENABLE, wd);
      m_en = wd[3:1];
      wd = $random(seed);
      write_reg(`SOC_REGION_IRQ, `SOC_IRQ_REG_SOFT, wd);
      m_soft = wd[0];
      repeat (2) @(negedge i_clk);
      src = {m_soft, m_mtip, |m_pend};
      check_value("o_irq", o_irq, |(src & m_en));
      read_reg(`SOC_REGION_IRQ, `SOC_IRQ_REG_PEND, rd);
      check_value("irq pend", rd, {src, 1'b0});
      read_reg(`SOC_REGION_IRQ, `SOC_IRQ_REG_CLAIM, rd);
      check_value("irq claim", rd, expected_claim(src & m_en));
    end
    check_shadow();
    finish_test("interrupt controller");

    $display("total %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
